// ==== run_sim.sh ====
#!/bin/sh
# builds the conv5 testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module conv5_tb --Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vconv5_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$log"; then
    echo "simulation reported failures, see $log"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== sim.f ====
src/conv5_pkg.sv
src/pixel_rx.sv
src/line_buffer.sv
src/window_5x5.sv
src/conv_mac.sv
src/result_tx.sv
src/conv5_top.sv
verif/conv5_tb.sv

// ==== src/conv5_pkg.sv ====
package conv5_pkg;

    // pixel width in bits
    localparam int pix_w = 8;

    // 255 * 256 fits in 16 bits
    localparam int acc_w = 16;

    // row and column counter width, frames up to 1023 x 1023
    localparam int coord_w = 10;

    // the kernel weights sum to 256
    localparam int norm_shift = 8;

    // steps that push the last centred column through the window and both MAC stages
    localparam int pipe_drain = 3;

    // outer product of 1 4 6 4 1 with itself, raster order of the window taps
    localparam int unsigned kernel [25] = '{
        1,  4,  6,  4, 1,
        4, 16, 24, 16, 4,
        6, 24, 36, 24, 6,
        4, 16, 24, 16, 4,
        1,  4,  6,  4, 1
    };

endpackage

// ==== src/conv5_top.sv ====
`timescale 1ns/1ps

module conv5_top #(
    parameter int ROWS = 6,
    parameter int COLS = 6
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_req_i,
    input  logic [conv5_pkg::pix_w-1:0] in_pixel_i,
    input  logic                        out_ack_i,
    output logic                        in_ack_o,
    output logic                        out_req_o,
    output logic [conv5_pkg::pix_w-1:0] out_pixel_o,
    output logic                        frame_done_o
);

    logic                              step;
    logic [conv5_pkg::pix_w-1:0]       beat_pixel;
    logic                              slot_free;
    logic [4:0][conv5_pkg::pix_w-1:0]  col_pixels;
    logic                              col_valid;
    logic [24:0][conv5_pkg::pix_w-1:0] taps;
    logic                              win_valid;
    logic                              win_last;
    logic [conv5_pkg::pix_w-1:0]       res_pixel;
    logic                              res_valid;
    logic                              res_last;

    pixel_rx #(.ROWS(ROWS), .COLS(COLS)) i_pixel_rx (
        .clk          (clk),
        .rst          (rst),
        .in_req_i     (in_req_i),
        .in_pixel_i   (in_pixel_i),
        .slot_free_i  (slot_free),
        .in_ack_o     (in_ack_o),
        .step_o       (step),
        .beat_pixel_o (beat_pixel)
    );

    line_buffer #(.COLS(COLS)) i_line_buffer (
        .clk          (clk),
        .rst          (rst),
        .step_i       (step),
        .pixel_i      (beat_pixel),
        .col_pixels_o (col_pixels),
        .col_valid_o  (col_valid)
    );

    window_5x5 #(.ROWS(ROWS), .COLS(COLS)) i_window_5x5 (
        .clk          (clk),
        .rst          (rst),
        .step_i       (step),
        .col_pixels_i (col_pixels),
        .col_valid_i  (col_valid),
        .taps_o       (taps),
        .win_valid_o  (win_valid),
        .win_last_o   (win_last)
    );

    conv_mac i_conv_mac (
        .clk         (clk),
        .rst         (rst),
        .step_i      (step),
        .taps_i      (taps),
        .win_valid_i (win_valid),
        .win_last_i  (win_last),
        .res_pixel_o (res_pixel),
        .res_valid_o (res_valid),
        .res_last_o  (res_last)
    );

    result_tx i_result_tx (
        .clk          (clk),
        .rst          (rst),
        .res_pixel_i  (res_pixel),
        .res_valid_i  (res_valid),
        .res_last_i   (res_last),
        .out_ack_i    (out_ack_i),
        .slot_free_o  (slot_free),
        .out_req_o    (out_req_o),
        .out_pixel_o  (out_pixel_o),
        .frame_done_o (frame_done_o)
    );

endmodule

// ==== src/conv_mac.sv ====
`timescale 1ns/1ps

module conv_mac (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              step_i,
    input  logic [24:0][conv5_pkg::pix_w-1:0] taps_i,
    input  logic                              win_valid_i,
    input  logic                              win_last_i,
    output logic [conv5_pkg::pix_w-1:0]       res_pixel_o,
    output logic                              res_valid_o,
    output logic                              res_last_o
);

    typedef logic [conv5_pkg::acc_w-1:0] acc_t;

    acc_t row_sum [5];
    acc_t row_q [5];
    acc_t total;
    acc_t scaled;
    logic v1_q;
    logic l1_q;

    always_comb begin
        for (int r = 0; r < 5; r++) begin
            row_sum[r] = '0;
            for (int k = 0; k < 5; k++) begin
                row_sum[r] = row_sum[r] + acc_t'(conv5_pkg::kernel[r*5+k] * taps_i[r*5+k]);
            end
        end
    end

    // weights sum to 256 so the total cannot wrap
    assign total  = row_q[0] + row_q[1] + row_q[2] + row_q[3] + row_q[4];
    assign scaled = total >> conv5_pkg::norm_shift;

    always_ff @(posedge clk) begin
        if (step_i) begin
            row_q       <= row_sum;
            res_pixel_o <= (scaled > acc_t'((1 << conv5_pkg::pix_w) - 1)) ?
                           {conv5_pkg::pix_w{1'b1}} : scaled[conv5_pkg::pix_w-1:0];
        end
    end

    // res_valid_o is a one-cycle pulse per result, the sender loads on it
    always_ff @(posedge clk) begin
        if (rst) begin
            v1_q        <= 1'b0;
            l1_q        <= 1'b0;
            res_valid_o <= 1'b0;
            res_last_o  <= 1'b0;
        end else begin
            res_valid_o <= step_i && v1_q;
            if (step_i) begin
                v1_q       <= win_valid_i;
                l1_q       <= win_last_i;
                res_last_o <= l1_q;
            end
        end
    end

endmodule

// ==== src/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer #(
    parameter int COLS = 6
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             step_i,
    input  logic [conv5_pkg::pix_w-1:0]      pixel_i,
    output logic [4:0][conv5_pkg::pix_w-1:0] col_pixels_o,
    output logic                             col_valid_o
);

    localparam int ptr_w = $clog2(COLS);

    // row_mem[i] holds the stream delayed by i+1 rows
    logic [conv5_pkg::pix_w-1:0] row_mem [4][COLS];
    logic [ptr_w-1:0]            ptr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q       <= '0;
            col_valid_o <= 1'b0;
        end else if (step_i) begin
            ptr_q       <= (ptr_q == ptr_w'(COLS - 1)) ? '0 : ptr_q + 1'b1;
            col_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (step_i) begin
            row_mem[0][ptr_q] <= pixel_i;
            for (int i = 1; i < 4; i++) begin
                row_mem[i][ptr_q] <= row_mem[i-1][ptr_q];
            end
            // slot 0 is the oldest row, slot 4 the incoming pixel
            for (int i = 0; i < 4; i++) begin
                col_pixels_o[i] <= row_mem[3-i][ptr_q];
            end
            col_pixels_o[4] <= pixel_i;
        end
    end

endmodule

// ==== src/pixel_rx.sv ====
`timescale 1ns/1ps

module pixel_rx #(
    parameter int ROWS = 6,
    parameter int COLS = 6
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_req_i,
    input  logic [conv5_pkg::pix_w-1:0] in_pixel_i,
    input  logic                        slot_free_i,
    output logic                        in_ack_o,
    output logic                        step_o,
    output logic [conv5_pkg::pix_w-1:0] beat_pixel_o
);

    localparam int frame_beats = ROWS * COLS;
    // window centre offset, then the stages behind the window
    localparam int flush_beats = 2 * COLS + 2 + conv5_pkg::pipe_drain;
    localparam int cnt_max = (frame_beats > flush_beats) ? frame_beats : flush_beats;
    localparam int cnt_w = $clog2(cnt_max + 1);

    logic             ack_q;
    logic             flushing_q;
    logic [cnt_w-1:0] beat_cnt_q;
    logic             take_pixel;
    logic             last_beat;

    // a pixel is taken only in a cycle where the whole pipeline steps with it
    assign take_pixel   = in_req_i && !ack_q && !flushing_q && slot_free_i;
    assign step_o       = take_pixel || (flushing_q && slot_free_i);
    assign beat_pixel_o = flushing_q ? '0 : in_pixel_i;
    assign in_ack_o     = ack_q;
    assign last_beat    = flushing_q ? (beat_cnt_q == cnt_w'(flush_beats - 1))
                                     : (beat_cnt_q == cnt_w'(frame_beats - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else if (take_pixel) begin
            ack_q <= 1'b1;
        end else if (ack_q && !in_req_i) begin
            ack_q <= 1'b0;
        end
    end

    // frame beats, then flush beats, then back to taking pixels
    always_ff @(posedge clk) begin
        if (rst) begin
            flushing_q <= 1'b0;
            beat_cnt_q <= '0;
        end else if (step_o) begin
            if (last_beat) begin
                flushing_q <= !flushing_q;
                beat_cnt_q <= '0;
            end else begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        in_req_i && !in_ack_o |=> in_req_i)
        else $error("in_req_i fell before in_ack_o was raised");

endmodule

// ==== src/result_tx.sv ====
`timescale 1ns/1ps

module result_tx (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [conv5_pkg::pix_w-1:0] res_pixel_i,
    input  logic                        res_valid_i,
    input  logic                        res_last_i,
    input  logic                        out_ack_i,
    output logic                        slot_free_o,
    output logic                        out_req_o,
    output logic [conv5_pkg::pix_w-1:0] out_pixel_o,
    output logic                        frame_done_o
);

    logic req_q;
    logic wait_q;
    logic last_q;
    logic done_now;

    // req dropped and ack seen low, the exchange ends this cycle
    assign done_now     = wait_q && !out_ack_i;
    assign slot_free_o  = !res_valid_i && (!(req_q || wait_q) || done_now);
    assign frame_done_o = done_now && last_q;
    assign out_req_o    = req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
        end else if (res_valid_i) begin
            req_q <= 1'b1;
        end else if (req_q && out_ack_i) begin
            req_q  <= 1'b0;
            wait_q <= 1'b1;
        end else if (done_now) begin
            wait_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            out_pixel_o <= res_pixel_i;
            last_q      <= res_last_i;
        end
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        res_valid_i |-> !(req_q || wait_q))
        else $error("result arrived while the holding register was full");

endmodule

// ==== src/window_5x5.sv ====
`timescale 1ns/1ps

module window_5x5 #(
    parameter int ROWS = 6,
    parameter int COLS = 6
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              step_i,
    input  logic [4:0][conv5_pkg::pix_w-1:0]  col_pixels_i,
    input  logic                              col_valid_i,
    output logic [24:0][conv5_pkg::pix_w-1:0] taps_o,
    output logic                              win_valid_o,
    output logic                              win_last_o
);

    localparam int prime_cols = 2 * COLS + 2;
    localparam int lead_max = prime_cols + conv5_pkg::pipe_drain;
    localparam int lead_w = $clog2(lead_max + 1);

    // win_q[row][col], row 0 on top, col 0 the oldest column
    logic [4:0][4:0][conv5_pkg::pix_w-1:0] win_q;
    logic [lead_w-1:0]                     lead_q;
    logic [conv5_pkg::coord_w-1:0]         row_cnt_q;
    logic [conv5_pkg::coord_w-1:0]         col_cnt_q;
    logic [conv5_pkg::coord_w-1:0]         cen_row_q;
    logic [conv5_pkg::coord_w-1:0]         cen_col_q;
    logic                                  shift;
    logic                                  centre;
    logic                                  frame_end;

    assign shift     = step_i && col_valid_i;
    assign centre    = (lead_q == lead_w'(lead_max));
    assign frame_end = (row_cnt_q == conv5_pkg::coord_w'(ROWS - 1)) &&
                       (col_cnt_q == conv5_pkg::coord_w'(COLS - 1));

    always_ff @(posedge clk) begin
        if (shift) begin
            for (int r = 0; r < 5; r++) begin
                for (int k = 0; k < 4; k++) begin
                    win_q[r][k] <= win_q[r][k+1];
                end
                win_q[r][4] <= col_pixels_i[r];
            end
        end
    end

    // lead_q counts columns that give no centre. the drain columns of one frame
    // belong to the lead of the next, so after reset it starts past them
    always_ff @(posedge clk) begin
        if (rst) begin
            lead_q      <= lead_w'(conv5_pkg::pipe_drain);
            row_cnt_q   <= '0;
            col_cnt_q   <= '0;
            cen_row_q   <= '0;
            cen_col_q   <= '0;
            win_valid_o <= 1'b0;
            win_last_o  <= 1'b0;
        end else if (shift) begin
            win_valid_o <= centre;
            win_last_o  <= centre && frame_end;
            if (!centre) begin
                lead_q <= lead_q + 1'b1;
            end else begin
                cen_row_q <= row_cnt_q;
                cen_col_q <= col_cnt_q;
                if (frame_end) begin
                    row_cnt_q <= '0;
                    col_cnt_q <= '0;
                    lead_q    <= '0;
                end else if (col_cnt_q == conv5_pkg::coord_w'(COLS - 1)) begin
                    col_cnt_q <= '0;
                    row_cnt_q <= row_cnt_q + 1'b1;
                end else begin
                    col_cnt_q <= col_cnt_q + 1'b1;
                end
            end
        end
    end

    // zero padding, taps outside the image read as 0
    always_comb begin
        int rr;
        int cc;
        for (int r = 0; r < 5; r++) begin
            for (int k = 0; k < 5; k++) begin
                rr = int'(cen_row_q) + r - 2;
                cc = int'(cen_col_q) + k - 2;
                if (rr < 0 || rr >= ROWS || cc < 0 || cc >= COLS) begin
                    taps_o[r*5+k] = '0;
                end else begin
                    taps_o[r*5+k] = win_q[r][k];
                end
            end
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        row_cnt_q < ROWS && col_cnt_q < COLS)
        else $error("window centre counters left the frame");

endmodule

// ==== verif/conv5_tb.sv ====
`timescale 1ns/1ps

module conv5_tb;

    localparam int frame_rows = 6;
    localparam int frame_cols = 6;
    localparam int frame_px = frame_rows * frame_cols;
    localparam int cycles_per_result = 40;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        in_req_i;
    logic [conv5_pkg::pix_w-1:0] in_pixel_i;
    logic                        out_ack_i;
    logic                        in_ack_o;
    logic                        out_req_o;
    logic [conv5_pkg::pix_w-1:0] out_pixel_o;
    logic                        frame_done_o;

    int    pix_q [$];
    int    exp_q [$];
    string name_q [$];
    int    mode_q [$];
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    rx_total = 0;
    int    done_cnt = 0;
    int    cycle_cnt = 0;
    int    cycle_limit = 0;
    logic  req_seen = 1'b0;
    logic  ack_seen = 1'b0;

    conv5_top #(.ROWS(frame_rows), .COLS(frame_cols)) i_conv5_top (
        .clk          (clk),
        .rst          (rst),
        .in_req_i     (in_req_i),
        .in_pixel_i   (in_pixel_i),
        .out_ack_i    (out_ack_i),
        .in_ack_o     (in_ack_o),
        .out_req_o    (out_req_o),
        .out_pixel_o  (out_pixel_o),
        .frame_done_o (frame_done_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles with %0d of %0d results received",
                     cycle_cnt, rx_total, name_q.size() * frame_px);
            $display("Finished with errors");
            $finish;
        end
    end

    // output handshake order and frame_done_o placement
    always @(posedge clk) begin
        if (!rst) begin
            if (req_seen && !out_req_o && !ack_seen) begin
                $display("out_req_o fell at %0t before out_ack_i was raised", $time);
                errors++;
            end
            if (!req_seen && out_req_o && out_ack_i) begin
                $display("out_req_o rose at %0t while out_ack_i was still high", $time);
                errors++;
            end
            if (frame_done_o) begin
                done_cnt++;
                if (rx_total != done_cnt * frame_px) begin
                    $display("frame_done_o pulsed at %0t after %0d results, expected after %0d",
                             $time, rx_total, done_cnt * frame_px);
                    errors++;
                end
            end
        end
        req_seen <= out_req_o;
        ack_seen <= out_ack_i;
    end

    // next line that is neither blank nor a comment
    function automatic int next_line(input int fd, output string line);
        int code;
        line = "";
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                return 1;
            end
        end
        return 0;
    endfunction

    task automatic load_tests();
        int    fd;
        int    mode;
        int    v [6];
        string line;
        string name;
        fd = $fopen("verif/conv5_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file verif/conv5_tests.txt");
            errors++;
            return;
        end
        while (next_line(fd, line)) begin
            if ($sscanf(line, "%s %d", name, mode) != 2) begin
                $display("malformed test header line: %s", line);
                errors++;
                break;
            end
            name_q.push_back(name);
            mode_q.push_back(mode);
            // 6 pixel rows, then 6 expected rows
            for (int k = 0; k < 2 * frame_rows; k++) begin
                if (!next_line(fd, line) || $sscanf(line, "%d %d %d %d %d %d",
                        v[0], v[1], v[2], v[3], v[4], v[5]) != frame_cols) begin
                    $display("test %s has a missing or short data row", name);
                    errors++;
                    break;
                end
                for (int j = 0; j < frame_cols; j++) begin
                    if (k < frame_rows) begin
                        pix_q.push_back(v[j]);
                    end else begin
                        exp_q.push_back(v[j]);
                    end
                end
            end
        end
        $fclose(fd);
        if (name_q.size() == 0 || exp_q.size() != name_q.size() * frame_px) begin
            $display("test data file holds no complete test");
            errors++;
        end
    endtask

    task automatic expect_low(input string sig, input logic val);
        checks++;
        if (val !== 1'b0) begin
            $display("CHECK FAILED at %0t: %s expected 0 got %b", $time, sig, val);
            errors++;
        end
    endtask

    task automatic send_frame(input int t, input bit rnd);
        int gap;
        for (int i = 0; i < frame_px; i++) begin
            gap = rnd ? int'($urandom % 6) : 0;
            repeat (gap) @(posedge clk);
            in_req_i   <= 1'b1;
            in_pixel_i <= conv5_pkg::pix_w'(pix_q[t * frame_px + i]);
            @(posedge clk);
            while (!in_ack_o) @(posedge clk);
            in_req_i <= 1'b0;
            @(posedge clk);
            while (in_ack_o) @(posedge clk);
        end
    endtask

    task automatic recv_frame(input int t, input bit rnd);
        int got;
        int want;
        int delay;
        for (int i = 0; i < frame_px; i++) begin
            @(posedge clk);
            while (!out_req_o) @(posedge clk);
            got   = int'(out_pixel_o);
            want  = exp_q[t * frame_px + i];
            delay = rnd ? int'($urandom % 6) : 0;
            repeat (delay) @(posedge clk);
            out_ack_i <= 1'b1;
            @(posedge clk);
            while (out_req_o) @(posedge clk);
            out_ack_i <= 1'b0;
            rx_total++;
            checks++;
            if (got != want) begin
                $display("CHECK FAILED at %0t: out_pixel_o result %0d expected %0d got %0d",
                         $time, i, want, got);
                errors++;
            end
        end
    endtask

    task automatic run_test(input int t);
        int err_before;
        int done_before;
        err_before  = errors;
        done_before = done_cnt;
        fork
            send_frame(t, mode_q[t] != 0);
            recv_frame(t, mode_q[t] != 0);
        join
        while (done_cnt == done_before) @(posedge clk);
        repeat (2) @(posedge clk);
        checks++;
        if (done_cnt != done_before + 1) begin
            $display("frame_done_o pulsed %0d times for test %s", done_cnt - done_before,
                     name_q[t]);
            errors++;
        end
        tests_run++;
        $display("test %s (%s): %0d results, %0d errors", name_q[t],
                 (mode_q[t] != 0) ? "random delays" : "immediate", frame_px,
                 errors - err_before);
    endtask

    initial begin
        int err_before;
        void'($urandom(89));
        rst        = 1'b1;
        in_req_i   = 1'b0;
        in_pixel_i = '0;
        out_ack_i  = 1'b0;
        load_tests();
        cycle_limit = cycles_per_result * frame_px * name_q.size();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // no request yet, so both handshakes stay quiet
        err_before = errors;
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            expect_low("in_ack_o", in_ack_o);
            expect_low("out_req_o", out_req_o);
            expect_low("frame_done_o", frame_done_o);
        end
        tests_run++;
        $display("test reset_state: %0d errors", errors - err_before);

        for (int t = 0; t < name_q.size(); t++) begin
            run_test(t);
        end

        // a duplicated result would show up here
        err_before = errors;
        for (int k = 0; k < 20; k++) begin
            @(posedge clk);
            expect_low("out_req_o", out_req_o);
        end
        tests_run++;
        $display("test no_extra_results: %0d errors", errors - err_before);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verif/conv5_tests.txt ====
# header line: test name, then mode (0 immediate handshakes, 1 random delays)
# then 6 rows of input pixels and 6 rows of expected results, decimal, raster order
ramp 0
0 7 14 21 28 35
42 49 56 63 70 77
84 91 98 105 112 119
126 133 140 147 154 161
168 175 182 189 196 203
210 217 224 231 238 245
12 19 25 30 32 25
33 48 57 64 65 50
60 86 98 105 104 79
89 125 140 147 143 108
107 149 165 171 166 124
90 125 138 143 138 103
flat255 0
255 255 255 255 255 255
255 255 255 255 255 255
255 255 255 255 255 255
255 255 255 255 255 255
255 255 255 255 255 255
255 255 255 255 255 255
120 164 175 175 164 120
164 224 239 239 224 164
175 239 255 255 239 175
175 239 255 255 239 175
164 224 239 239 224 164
120 164 175 175 164 120
ramp_delayed 1
0 7 14 21 28 35
42 49 56 63 70 77
84 91 98 105 112 119
126 133 140 147 154 161
168 175 182 189 196 203
210 217 224 231 238 245
12 19 25 30 32 25
33 48 57 64 65 50
60 86 98 105 104 79
89 125 140 147 143 108
107 149 165 171 166 124
90 125 138 143 138 103
